//--- src/ctrl_pkg.sv
// Register map, widths and reset values; the settings bus is assumed to be on dsp_clk
package ctrl_pkg;

   ////////////////////
   // Widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int CTRL_W     = 8;
   localparam int TIME_W     = 64;
   localparam int RB_ADDR_W  = 4;
   localparam int RB_DATA_W  = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [CTRL_W-1:0]     ctrl_word_t;
   typedef logic [TIME_W-1:0]     vita_time_t;
   typedef logic [RB_ADDR_W-1:0]  rb_addr_t;
   typedef logic [RB_DATA_W-1:0]  rb_word_t;

   ////////////////////
   // Settings bus register map
   localparam set_addr_t SR_MISC      = 8'd0;   // 7 regs
   localparam set_addr_t SR_TIME64    = 8'd10;  // 3 regs used here
   localparam set_addr_t MISC_CLK     = 8'd0;
   localparam set_addr_t MISC_SER     = 8'd1;
   localparam set_addr_t MISC_ADC     = 8'd2;
   localparam set_addr_t MISC_LED_SW  = 8'd3;
   localparam set_addr_t MISC_PHY     = 8'd4;
   localparam set_addr_t MISC_LED_SRC = 8'd6;
   localparam set_addr_t TIME_PEND_HI = 8'd0;
   localparam set_addr_t TIME_PEND_LO = 8'd1;
   localparam set_addr_t TIME_LOAD    = 8'd2;   // Bit 0 set loads now

   // Reset values
   localparam ctrl_word_t CTRL_AT_RESET    = 8'h00;
   localparam ctrl_word_t LED_SRC_AT_RESET = 8'h1E;  // 1 = hardware drives the LED

   ////////////////////
   // Readback map
   localparam rb_word_t COMPAT_NUM = {16'd7, 16'd1};  // Major, minor
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

   typedef enum logic {LOAD_IDLE, LOAD_ARMED} load_state_t;

endpackage

//--- src/misc_settings.sv
// Misc control registers; a write lands one cycle after the strobe, unmapped addresses ignored
`timescale 1ns/1ps

module misc_settings (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 set_stb_i,
   input  ctrl_pkg::set_addr_t  set_addr_i,
   input  ctrl_pkg::set_data_t  set_data_i,
   output ctrl_pkg::ctrl_word_t clk_ctrl_o,
   output ctrl_pkg::ctrl_word_t ser_ctrl_o,
   output ctrl_pkg::ctrl_word_t adc_ctrl_o,
   output ctrl_pkg::ctrl_word_t led_sw_o,
   output ctrl_pkg::ctrl_word_t led_src_o,
   output logic                 phy_reset_n_o
);

   ctrl_pkg::ctrl_word_t clk_ctrl;
   ctrl_pkg::ctrl_word_t ser_ctrl;
   ctrl_pkg::ctrl_word_t adc_ctrl;
   ctrl_pkg::ctrl_word_t led_sw;
   ctrl_pkg::ctrl_word_t led_src;
   ctrl_pkg::ctrl_word_t wr_byte;
   logic                 phy_reset;

   assign wr_byte = set_data_i[ctrl_pkg::CTRL_W-1:0];  // Only the low byte is kept

   ////////////////////
   // Register file
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_ctrl  <= ctrl_pkg::CTRL_AT_RESET;
         ser_ctrl  <= ctrl_pkg::CTRL_AT_RESET;
         adc_ctrl  <= ctrl_pkg::CTRL_AT_RESET;
         led_sw    <= ctrl_pkg::CTRL_AT_RESET;
         led_src   <= ctrl_pkg::LED_SRC_AT_RESET;  // Status LEDs on hardware
         phy_reset <= 1'b0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_CLK:     clk_ctrl  <= wr_byte;
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_SER:     ser_ctrl  <= wr_byte;
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_ADC:     adc_ctrl  <= wr_byte;
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SW:  led_sw    <= wr_byte;
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_PHY:     phy_reset <= set_data_i[0];
            ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SRC: led_src   <= wr_byte;
            default: ;
         endcase
      end
   end

   assign clk_ctrl_o = clk_ctrl;
   assign ser_ctrl_o = ser_ctrl;
   assign adc_ctrl_o = adc_ctrl;
   assign led_sw_o   = led_sw;
   assign led_src_o  = led_src;

   // PHY pin is active low
   assign phy_reset_n_o = ~phy_reset;

endmodule

//--- src/vita_timer.sv
// 64-bit VITA time; write both pending words before the load command, pps_i is asynchronous
`timescale 1ns/1ps

module vita_timer (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 set_stb_i,
   input  ctrl_pkg::set_addr_t  set_addr_i,
   input  ctrl_pkg::set_data_t  set_data_i,
   input  logic                 pps_i,
   output ctrl_pkg::vita_time_t vita_time_o,
   output ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                 pps_int_o
);

   ctrl_pkg::set_data_t   pend_hi;
   ctrl_pkg::set_data_t   pend_lo;
   ctrl_pkg::vita_time_t  pend_time;
   ctrl_pkg::vita_time_t  vita_time;
   ctrl_pkg::vita_time_t  vita_time_pps;
   ctrl_pkg::load_state_t load_state;
   logic                  load_cmd;
   logic                  load_now;
   logic                  arm_load;
   logic                  pps_load;
   logic                  pps_meta;
   logic                  pps_sync;
   logic                  pps_last;
   logic                  pps_edge;
   logic                  pps_int;

   ////////////////////
   // Pending time and load command decode
   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && set_addr_i == ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_HI) begin
         pend_hi <= set_data_i;
      end
      if (set_stb_i && set_addr_i == ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_LO) begin
         pend_lo <= set_data_i;
      end
   end

   assign pend_time = {pend_hi, pend_lo};
   assign load_cmd  = set_stb_i && set_addr_i == ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_LOAD;
   assign load_now  = load_cmd & set_data_i[0];
   assign arm_load  = load_cmd & ~set_data_i[0];
   assign pps_load  = pps_edge && load_state == ctrl_pkg::LOAD_ARMED;

   // Load FSM
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         load_state <= ctrl_pkg::LOAD_IDLE;
      end else begin
         case (load_state)
            ctrl_pkg::LOAD_IDLE:  if (arm_load) load_state <= ctrl_pkg::LOAD_ARMED;
            ctrl_pkg::LOAD_ARMED: if (load_now || pps_edge) load_state <= ctrl_pkg::LOAD_IDLE;
            default:              load_state <= ctrl_pkg::LOAD_IDLE;
         endcase
      end
   end

   ////////////////////
   // PPS sync, edge detect and capture
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta      <= 1'b0;
         pps_sync      <= 1'b0;
         pps_last      <= 1'b0;
         pps_edge      <= 1'b0;
         pps_int       <= 1'b0;
         vita_time_pps <= '0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_last <= pps_sync;
         pps_edge <= pps_sync & ~pps_last;  // Registered rising edge
         pps_int  <= pps_edge;
         if (pps_edge) begin
            vita_time_pps <= pps_load ? pend_time : vita_time;
         end
      end
   end

   // Free-running time
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time <= '0;
      end else if (load_now || pps_load) begin
         vita_time <= pend_time;
      end else begin
         vita_time <= vita_time + 64'd1;
      end
   end

   assign vita_time_o     = vita_time;
   assign vita_time_pps_o = vita_time_pps;
   assign pps_int_o       = pps_int;

endmodule

//--- src/status_combiner.sv
// LED source merge and registered readback; unmapped readback indices return zero
`timescale 1ns/1ps

module status_combiner (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  ctrl_pkg::ctrl_word_t led_sw_i,
   input  ctrl_pkg::ctrl_word_t led_src_i,
   input  logic                 run_rx_i,
   input  logic                 run_tx_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   input  ctrl_pkg::rb_addr_t   rb_addr_i,
   input  ctrl_pkg::vita_time_t vita_time_i,
   input  ctrl_pkg::vita_time_t vita_time_pps_i,
   output ctrl_pkg::ctrl_word_t leds_o,
   output ctrl_pkg::rb_word_t   rb_data_o
);

   ctrl_pkg::ctrl_word_t led_hw;
   ctrl_pkg::rb_word_t   rb_next;
   ctrl_pkg::rb_word_t   rb_data;

   ////////////////////
   // LEDs
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};

   // Per bit select, 1 picks hardware
   assign leds_o = (led_src_i & led_hw) | (~led_src_i & led_sw_i);

   ////////////////////
   // Readback mux
   always_comb begin
      case (rb_addr_i)
         ctrl_pkg::RB_TIME_HI: rb_next = vita_time_i[63:32];
         ctrl_pkg::RB_TIME_LO: rb_next = vita_time_i[31:0];
         ctrl_pkg::RB_COMPAT:  rb_next = ctrl_pkg::COMPAT_NUM;
         ctrl_pkg::RB_PPS_HI:  rb_next = vita_time_pps_i[63:32];
         ctrl_pkg::RB_PPS_LO:  rb_next = vita_time_pps_i[31:0];
         default:              rb_next = '0;  // Status and irq words too
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data <= '0;
      end else begin
         rb_data <= rb_next;
      end
   end

   assign rb_data_o = rb_data;

endmodule

//--- src/ctrl_core_top.sv
// DSP-clock control slice top; settings bus and readback index are synchronous to dsp_clk
`timescale 1ns/1ps

module ctrl_core_top (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 set_stb_i,
   input  ctrl_pkg::set_addr_t  set_addr_i,
   input  ctrl_pkg::set_data_t  set_data_i,
   input  logic                 pps_i,
   input  logic                 run_rx_i,
   input  logic                 run_tx_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   input  ctrl_pkg::rb_addr_t   rb_addr_i,
   output ctrl_pkg::ctrl_word_t clk_ctrl_o,
   output ctrl_pkg::ctrl_word_t ser_ctrl_o,
   output ctrl_pkg::ctrl_word_t adc_ctrl_o,
   output logic                 phy_reset_n_o,
   output logic                 pps_int_o,
   output ctrl_pkg::ctrl_word_t leds_o,
   output ctrl_pkg::rb_word_t   rb_data_o
);

   ctrl_pkg::ctrl_word_t led_sw;
   ctrl_pkg::ctrl_word_t led_src;
   ctrl_pkg::vita_time_t vita_time;
   ctrl_pkg::vita_time_t vita_time_pps;

   ////////////////////
   // Settings decode and time base
   misc_settings misc_settings_inst (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .clk_ctrl_o(clk_ctrl_o), .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .led_sw_o(led_sw), .led_src_o(led_src), .phy_reset_n_o(phy_reset_n_o)
   );

   vita_timer vita_timer_inst (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o)
   );

   // LEDs and readback
   status_combiner status_combiner_inst (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .led_sw_i(led_sw), .led_src_i(led_src),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .rb_addr_i(rb_addr_i), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .leds_o(leds_o), .rb_data_o(rb_data_o)
   );

endmodule

//--- tests/ctrl_core_props.sv
// Bound to ctrl_core_top; por_rst must be high at the first dsp_clk edge for the reset checks
`timescale 1ns/1ps

module ctrl_core_props (
   input logic                 dsp_clk,
   input logic                 por_rst,
   input logic                 pps_int_o,
   input logic                 phy_reset_n_o,
   input ctrl_pkg::ctrl_word_t clk_ctrl_o,
   input ctrl_pkg::ctrl_word_t ser_ctrl_o,
   input ctrl_pkg::ctrl_word_t adc_ctrl_o
);

   int fail_cnt = 0;  // Failed assertion count

   // Interrupt is a single-cycle pulse
   pps_pulse_a: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o)
      else begin
         $error("pps_int_o high for two consecutive cycles");
         fail_cnt++;
      end

   phy_out_of_reset_a: assert property (@(posedge dsp_clk) por_rst |=> phy_reset_n_o)
      else begin
         $error("phy_reset_n_o low one cycle after reset");
         fail_cnt++;
      end

   ctrl_zero_a: assert property (@(posedge dsp_clk)
      por_rst |=> (clk_ctrl_o == 8'h00 && ser_ctrl_o == 8'h00 && adc_ctrl_o == 8'h00))
      else begin
         $error("Control words not zero after reset");
         fail_cnt++;
      end

endmodule

bind ctrl_core_top ctrl_core_props props_inst (
   .dsp_clk(dsp_clk), .por_rst(por_rst), .pps_int_o(pps_int_o),
   .phy_reset_n_o(phy_reset_n_o), .clk_ctrl_o(clk_ctrl_o),
   .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o)
);

//--- tests/ctrl_core_tb.sv
// Self-checking testbench; inputs change 10 ns after the rising edge, needs --timing
`timescale 1ns/1ps

module ctrl_core_tb;

   logic                 dsp_clk;
   logic                 por_rst;
   logic                 set_stb_i;
   ctrl_pkg::set_addr_t  set_addr_i;
   ctrl_pkg::set_data_t  set_data_i;
   logic                 pps_i;
   logic                 run_rx_i;
   logic                 run_tx_i;
   logic                 clk_status_i;
   logic                 link_up_i;
   ctrl_pkg::rb_addr_t   rb_addr_i;
   ctrl_pkg::ctrl_word_t clk_ctrl_o;
   ctrl_pkg::ctrl_word_t ser_ctrl_o;
   ctrl_pkg::ctrl_word_t adc_ctrl_o;
   logic                 phy_reset_n_o;
   logic                 pps_int_o;
   ctrl_pkg::ctrl_word_t leds_o;
   ctrl_pkg::rb_word_t   rb_data_o;
   logic [31:0]          lfsr;
   ctrl_pkg::ctrl_word_t m_led_sw;   // Model of the LED registers
   ctrl_pkg::ctrl_word_t m_led_src;
   string                cur_test;
   int                   errors = 0;
   int                   test_errs = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;

   ctrl_core_top ctrl_core_top_inst (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .pps_i(pps_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .rb_addr_i(rb_addr_i),
      .clk_ctrl_o(clk_ctrl_o), .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .pps_int_o(pps_int_o), .leds_o(leds_o),
      .rb_data_o(rb_data_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #50 dsp_clk = ~dsp_clk;  // 100 ns period
   end

   ////////////////////
   // Helpers
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32,22,2,1
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   // Bit 1 link, 2 clock status, 3 rx, 4 tx; src bit set selects hardware
   function automatic ctrl_pkg::ctrl_word_t expected_leds(input ctrl_pkg::ctrl_word_t sw,
         input ctrl_pkg::ctrl_word_t src, input logic tx, input logic rx,
         input logic clk_ok, input logic link);
      ctrl_pkg::ctrl_word_t hw;
      ctrl_pkg::ctrl_word_t res;
      hw    = 8'h00;
      hw[1] = link;
      hw[2] = clk_ok;
      hw[3] = rx;
      hw[4] = tx;
      for (int i = 0; i < 8; i++) begin
         res[i] = src[i] ? hw[i] : sw[i];
      end
      return res;
   endfunction

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         errors++;
         $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic tick();
      @(posedge dsp_clk);
      #10;
   endtask

   task automatic write_reg(input ctrl_pkg::set_addr_t addr, input ctrl_pkg::set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      tick();
      set_stb_i = 1'b0;
   endtask

   task automatic read_rb(input ctrl_pkg::rb_addr_t addr, output logic [31:0] data);
      rb_addr_i = addr;
      tick();
      data = rb_data_o;
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == test_errs) begin
         $display("Test %s passed", cur_test);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", cur_test, errors - test_errs);
      end
   endtask

   ////////////////////
   // LED register model and compare
   always @(posedge dsp_clk) begin
      if (por_rst) begin
         m_led_sw  <= 8'h00;
         m_led_src <= 8'h1E;
      end else if (set_stb_i && set_addr_i == ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SW) begin
         m_led_sw <= set_data_i[7:0];
      end else if (set_stb_i && set_addr_i == ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SRC) begin
         m_led_src <= set_data_i[7:0];
      end
   end

   always @(negedge dsp_clk) begin
      if (!por_rst) begin
         check_val("leds_o", 64'(expected_leds(m_led_sw, m_led_src, run_tx_i, run_rx_i,
            clk_status_i, link_up_i)), 64'(leds_o));
      end
   end

   ////////////////////
   // Test sequence
   initial begin
      logic [31:0] rnd;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] diff;
      int          k;
      int          waited;
      lfsr       = 32'd85318;
      rnd        = rand_bits(4);
      por_rst    = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      pps_i      = 1'b0;
      rb_addr_i  = '0;
      run_tx_i     = rnd[3];
      run_rx_i     = rnd[2];
      clk_status_i = rnd[1];
      link_up_i    = rnd[0];
      repeat (3) tick();
      por_rst = 1'b0;

      start_test("reset_state");
      check_val("clk_ctrl_o", 64'd0, 64'(clk_ctrl_o));
      check_val("ser_ctrl_o", 64'd0, 64'(ser_ctrl_o));
      check_val("adc_ctrl_o", 64'd0, 64'(adc_ctrl_o));
      check_val("phy_reset_n_o", 64'd1, 64'(phy_reset_n_o));
      check_val("leds_o", 64'({3'b000, rnd[3:0], 1'b0} & 8'h1E), 64'(leds_o));
      end_test();

      start_test("reg_writes");
      rnd = rand_bits(32);
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_CLK, rnd);
      check_val("clk_ctrl_o", 64'(rnd[7:0]), 64'(clk_ctrl_o));
      rnd = rand_bits(32);
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_SER, rnd);
      check_val("ser_ctrl_o", 64'(rnd[7:0]), 64'(ser_ctrl_o));
      rnd = rand_bits(32);
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_ADC, rnd);
      check_val("adc_ctrl_o", 64'(rnd[7:0]), 64'(adc_ctrl_o));
      rnd = rand_bits(32);
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_PHY, rnd);
      check_val("phy_reset_n_o", {63'd0, ~rnd[0]}, 64'(phy_reset_n_o));
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SW, rand_bits(32));  // Seen on leds_o
      write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SRC, rand_bits(32));
      hi = {clk_ctrl_o, ser_ctrl_o, adc_ctrl_o, 7'd0, phy_reset_n_o};
      for (int a = 5; a < 10; a++) begin
         if (a != 6) begin
            write_reg(8'(a), rand_bits(32));
         end
      end
      write_reg(8'hFF, rand_bits(32));
      check_val("unmapped writes", 64'(hi),
         64'({clk_ctrl_o, ser_ctrl_o, adc_ctrl_o, 7'd0, phy_reset_n_o}));
      end_test();

      start_test("led_merge");
      for (int i = 0; i < 16; i++) begin
         rnd = rand_bits(20);
         write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SW, {24'd0, rnd[7:0]});
         write_reg(ctrl_pkg::SR_MISC + ctrl_pkg::MISC_LED_SRC, {24'd0, rnd[15:8]});
         run_tx_i     = rnd[16];
         run_rx_i     = rnd[17];
         clk_status_i = rnd[18];
         link_up_i    = rnd[19];
         tick();
         check_val("leds_o", 64'(expected_leds(rnd[7:0], rnd[15:8], rnd[16], rnd[17],
            rnd[18], rnd[19])), 64'(leds_o));
      end
      end_test();

      start_test("readback");
      read_rb(4'd12, r1);
      check_val("compat", 64'h0000_0000_0007_0001, 64'(r1));
      for (int a = 0; a < 14; a++) begin
         if (a < 10 || a == 13) begin
            read_rb(4'(a), r1);
            check_val("unmapped readback", 64'd0, 64'(r1));
         end
      end
      end_test();

      start_test("load_now");
      hi  = rand_bits(32);
      rnd = rand_bits(16);
      lo  = {16'h1000, rnd[15:0]};  // Far from a carry into the high word
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_HI, hi);
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_LO, lo);
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_LOAD, 32'd1);
      read_rb(4'd10, r1);
      check_val("time high", 64'(hi), 64'(r1));
      read_rb(4'd11, r1);
      rnd = rand_bits(3);
      k   = int'(rnd[2:0]) + 2;
      repeat (k) tick();
      r2   = rb_data_o;
      diff = r2 - r1;
      check_val("time low delta", 64'(k), 64'(diff));
      end_test();

      start_test("pps_load");
      hi  = rand_bits(32);
      rnd = rand_bits(16);
      lo  = {16'h2000, rnd[15:0]};
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_HI, hi);
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_PEND_LO, lo);
      write_reg(ctrl_pkg::SR_TIME64 + ctrl_pkg::TIME_LOAD, 32'd0);  // Arm for next PPS
      pps_i  = 1'b1;
      waited = 0;
      while (!pps_int_o && waited < 20) begin
         tick();
         waited++;
      end
      if (!pps_int_o) begin
         errors++;
         $display("Timeout in %s: pps_int_o did not pulse within 20 cycles", cur_test);
      end else begin
         check_val("pps_int latency", 64'd4, 64'(waited));
      end
      pps_i = 1'b0;
      read_rb(4'd14, r1);
      check_val("pps time high", 64'(hi), 64'(r1));
      read_rb(4'd15, r1);
      check_val("pps time low", 64'(lo), 64'(r1));
      read_rb(4'd10, r1);
      check_val("time high", 64'(hi), 64'(r1));
      end_test();

      if (ctrl_core_top_inst.props_inst.fail_cnt != 0) begin
         errors++;
         $display("Bound assertions failed %0d times", ctrl_core_top_inst.props_inst.fail_cnt);
      end
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
src/ctrl_pkg.sv
src/misc_settings.sv
src/vita_timer.sv
src/status_combiner.sv
src/ctrl_core_top.sv
tests/ctrl_core_props.sv
tests/ctrl_core_tb.sv

//--- Makefile
# Verilator build and run for the DSP-clock control slice
VERILATOR ?= verilator
TOP       ?= ctrl_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps -Wall
RUN_ARGS  ?= +verilator+error+limit+100
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
